// File: project.f
egress_pkg.sv
sync_fifo.sv
pri_queue.sv
frame_sched.sv
frame_tx.sv
cross_data_cache.sv
tb_cross_data_cache.sv

// File: Bender.yml
package:
  name: cross_data_cache

sources:
  - egress_pkg.sv
  - sync_fifo.sv
  - pri_queue.sv
  - frame_sched.sv
  - frame_tx.sv
  - cross_data_cache.sv
  - target: simulation
    files:
      - tb_cross_data_cache.sv

// File: tb_cross_data_cache.sv
module tb_cross_data_cache;

    timeunit 1ns;
    timeprecision 100ps;

    import egress_pkg::*;

    localparam int PRI_NUM   = DEF_PRI_NUM;
    localparam int DATA_W    = DEF_DATA_W;
    localparam int MAX_FRAME = DEF_MAX_FRAME;
    localparam int MAX_WAIT  = 5000;   // Cycles per bounded wait
    localparam int TABLE_SZ  = 128;

    typedef logic [DATA_W-1:0] frame_t [MAX_FRAME];

    logic                           i_clk = 1'b0;
    logic                           i_rst;
    logic [PRI_NUM-1:0][DATA_W-1:0] i_data;
    logic [PRI_NUM-1:0]             i_data_vld;
    logic [PRI_NUM-1:0][META_W-1:0] i_meta;
    logic [PRI_NUM-1:0]             i_meta_vld;
    logic [PRI_NUM-1:0]             o_pri_ready;
    logic [PRI_NUM-1:0]             o_fifoc_empty;
    logic [DATA_W-1:0]              o_emac_tx_data;
    logic                           o_emac_tx_valid;
    logic                           o_emac_tx_last;
    logic                           i_emac_tx_ready;
    logic [DATA_W-1:0]              o_pmac_tx_data;
    logic                           o_pmac_tx_valid;
    logic                           o_pmac_tx_last;
    logic                           i_pmac_tx_ready;

    // Reference model with one entry per frame in send order
    int                n_frames = 0;
    int                n_done   = 0;
    int                f_pri   [TABLE_SZ];
    logic              f_exp   [TABLE_SZ];
    int                f_len   [TABLE_SZ];
    int                f_off   [TABLE_SZ];
    int                f_stamp [TABLE_SZ];   // Edge that wrote the metadata
    logic              f_done  [TABLE_SZ];
    logic [DATA_W-1:0] pool [$];
    int                got_order [$];

    // Collector state per channel (0 pmac and 1 emac)
    logic [DATA_W-1:0] rx_buf [2][MAX_FRAME];
    int                rx_cnt [2];
    int                rx_first [2];
    int                vld_cycles [2];
    logic              rx_hold [2];
    logic [DATA_W-1:0] rx_hold_data [2];
    logic              rx_hold_last [2];

    int          seed      = 75807;
    int          cyc       = 0;
    logic        toggle_on = 1'b0;
    logic [31:0] rnd_ready;
    frame_t      tx_bytes;

    cross_data_cache #(
        .DATA_W     (DATA_W),
        .PRI_NUM    (PRI_NUM),
        .DATA_DEPTH (DEF_DATA_DEPTH),
        .META_DEPTH (DEF_META_DEPTH),
        .MAX_FRAME  (MAX_FRAME)
    ) i_cross_data_cache (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_data          (i_data),
        .i_data_vld      (i_data_vld),
        .i_meta          (i_meta),
        .i_meta_vld      (i_meta_vld),
        .o_pri_ready     (o_pri_ready),
        .o_fifoc_empty   (o_fifoc_empty),
        .o_emac_tx_data  (o_emac_tx_data),
        .o_emac_tx_valid (o_emac_tx_valid),
        .o_emac_tx_last  (o_emac_tx_last),
        .i_emac_tx_ready (i_emac_tx_ready),
        .o_pmac_tx_data  (o_pmac_tx_data),
        .o_pmac_tx_valid (o_pmac_tx_valid),
        .o_pmac_tx_last  (o_pmac_tx_last),
        .i_pmac_tx_ready (i_pmac_tx_ready)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    // Random back-pressure on both channels
    always @(negedge i_clk) begin
        if (toggle_on) begin
            rnd_ready       = $random(seed);
            i_emac_tx_ready = rnd_ready[0];
            i_pmac_tx_ready = rnd_ready[1];
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst) begin
            check("both channels valid", o_emac_tx_valid & o_pmac_tx_valid, 0);
            take_byte(0, o_pmac_tx_valid, i_pmac_tx_ready, o_pmac_tx_data, o_pmac_tx_last);
            take_byte(1, o_emac_tx_valid, i_emac_tx_ready, o_emac_tx_data, o_emac_tx_last);
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                                $time, what, got, exp));
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic fill_random();
        for (int i = 0; i < MAX_FRAME; i++) begin
            tx_bytes[i] = DATA_W'(rand_below(256));
        end
    endtask

    task automatic wait_ready(input int p);
        int n;
        n = 0;
        while (o_pri_ready[p] !== 1'b1) begin
            if (n == MAX_WAIT) begin
                abort_run($sformatf("Timeout: queue %0d never became ready", p));
            end else begin
                n++;
                @(negedge i_clk);
            end
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (n_done != n_frames) begin
            if (n == MAX_WAIT) begin
                abort_run($sformatf("Timeout: only %0d of %0d frames came out",
                                    n_done, n_frames));
            end else begin
                n++;
                @(negedge i_clk);
            end
        end
        repeat (2) @(negedge i_clk);
    endtask

    // Starts and ends on a falling edge
    task automatic send_frame(input int p, input logic express, input int len,
                              input frame_t bytes);
        wait_ready(p);
        check("frame table has room", n_frames < TABLE_SZ, 1);
        f_pri[n_frames]  = p;
        f_exp[n_frames]  = express;
        f_len[n_frames]  = len;
        f_off[n_frames]  = pool.size();
        f_done[n_frames] = 1'b0;
        for (int i = 0; i < len; i++) begin
            pool.push_back(bytes[i]);
            i_data[p]     = bytes[i];
            i_data_vld[p] = 1'b1;
            @(negedge i_clk);
        end
        i_data_vld[p] = 1'b0;
        i_meta[p]     = {express, LEN_W'(len)};
        i_meta_vld[p] = 1'b1;
        @(posedge i_clk);
        f_stamp[n_frames] = cyc;
        n_frames++;
        @(negedge i_clk);
        i_meta_vld[p] = 1'b0;
    endtask

    // Received frame must be the head of some queue and nothing higher may have waited
    task automatic match_frame(input int ch);
        int   head [PRI_NUM];
        int   hit;
        int   j;
        logic same;
        hit = -1;
        for (int p = 0; p < PRI_NUM; p++) head[p] = -1;
        for (int i = 0; i < n_frames; i++) begin
            if (!f_done[i] && head[f_pri[i]] < 0) head[f_pri[i]] = i;
        end
        for (int p = 0; p < PRI_NUM; p++) begin
            j = head[p];
            if (j >= 0 && f_exp[j] == (ch == 1) && f_len[j] == rx_cnt[ch]) begin
                same = 1'b1;
                for (int k = 0; k < f_len[j]; k++) begin
                    if (pool[f_off[j] + k] !== rx_buf[ch][k]) same = 1'b0;
                end
                if (same) hit = j;
            end
        end
        check($sformatf("%s frame of %0d bytes matches a queue head",
                        (ch == 1) ? "emac" : "pmac", rx_cnt[ch]), hit >= 0, 1);
        for (int i = 0; i < n_frames; i++) begin
            if (!f_done[i] && i != hit && f_pri[i] > f_pri[hit]) begin
                check($sformatf("queue %0d frame was waiting while queue %0d got the grant",
                                f_pri[i], f_pri[hit]), f_stamp[i] > rx_first[ch] - 3, 1);
            end
        end
        f_done[hit] = 1'b1;
        got_order.push_back(hit);
        n_done++;
    endtask

    task automatic take_byte(input int ch, input logic vld, input logic rdy,
                             input logic [DATA_W-1:0] data, input logic last);
        if (rx_hold[ch]) begin
            check("valid held under back-pressure", vld, 1);
            check("data held under back-pressure", data, rx_hold_data[ch]);
            check("last held under back-pressure", last, rx_hold_last[ch]);
        end
        rx_hold[ch]      = vld & ~rdy;
        rx_hold_data[ch] = data;
        rx_hold_last[ch] = last;
        if (vld) vld_cycles[ch]++;
        if (vld && rx_first[ch] < 0) rx_first[ch] = cyc;
        if (vld && rdy) begin
            check("output frame within length limit", rx_cnt[ch] < MAX_FRAME, 1);
            rx_buf[ch][rx_cnt[ch]] = data;
            rx_cnt[ch]++;
            if (last) begin
                match_frame(ch);
                rx_cnt[ch]   = 0;
                rx_first[ch] = -1;
            end
        end
    endtask

    task automatic test_reset();
        int n;
        for (int c = 0; c < 10; c++) begin
            @(negedge i_clk);
            check("emac valid in reset", o_emac_tx_valid, 0);
            check("pmac valid in reset", o_pmac_tx_valid, 0);
            check("pri_ready in reset", o_pri_ready, 0);
            check("fifoc_empty in reset", o_fifoc_empty, {PRI_NUM{1'b1}});
        end
        i_rst = 1'b0;
        n = 0;
        while (o_pri_ready !== {PRI_NUM{1'b1}}) begin
            if (n == 4) begin
                abort_run("Timeout: queues not ready after reset release");
            end else begin
                n++;
                @(negedge i_clk);
            end
        end
    endtask

    // One frame on a single channel while the other stays quiet
    task automatic test_single(input int p, input logic express);
        int len;
        int quiet;
        len   = 1 + rand_below(MAX_FRAME);
        quiet = vld_cycles[express ? 0 : 1];
        fill_random();
        send_frame(p, express, len, tx_bytes);
        check("fifoc_empty with frame stored", o_fifoc_empty[p], 0);
        wait_drained();
        check("other channel valid cycles", vld_cycles[express ? 0 : 1], quiet);
        check("fifoc_empty after frame", o_fifoc_empty[p], 1);
    endtask

    task automatic test_strict_priority();
        int a;
        int b;
        int c;
        int n;
        int base;
        i_pmac_tx_ready = 1'b0;
        a = n_frames;
        fill_random();
        send_frame(1, 1'b0, 1 + rand_below(MAX_FRAME), tx_bytes);
        n = 0;
        while (o_pmac_tx_valid !== 1'b1) begin
            if (n == MAX_WAIT) begin
                abort_run("Timeout: pmac valid never rose for the first frame");
            end else begin
                n++;
                @(negedge i_clk);
            end
        end
        b = n_frames;
        fill_random();
        send_frame(1, 1'b0, 1 + rand_below(MAX_FRAME), tx_bytes);
        c = n_frames;
        fill_random();
        send_frame(6, 1'b0, 1 + rand_below(MAX_FRAME), tx_bytes);
        i_pmac_tx_ready = 1'b1;
        wait_drained();
        base = got_order.size() - 3;
        check("first frame out", got_order[base], a);
        check("second frame out", got_order[base + 1], c);
        check("third frame out", got_order[base + 2], b);
    endtask

    task automatic test_backpressure();
        int   sent;
        int   p;
        int   len;
        logic express;
        i_pmac_tx_ready = 1'b0;
        i_emac_tx_ready = 1'b1;
        sent = 0;
        while (o_pri_ready[3] && sent < 8) begin
            fill_random();
            send_frame(3, 1'b0, MAX_FRAME, tx_bytes);
            @(negedge i_clk);
            sent++;
        end
        check("pri_ready[3] after filling", o_pri_ready[3], 0);
        toggle_on = 1'b1;
        for (int f = 0; f < 40; f++) begin
            p       = rand_below(PRI_NUM);
            express = (rand_below(2) == 1);
            len     = 1 + rand_below(MAX_FRAME);
            fill_random();
            send_frame(p, express, len, tx_bytes);
        end
        toggle_on = 1'b0;
        @(negedge i_clk);
        i_emac_tx_ready = 1'b1;
        i_pmac_tx_ready = 1'b1;
        wait_drained();
    endtask

    initial begin
        i_rst           = 1'b1;
        i_data          = '0;
        i_data_vld      = '0;
        i_meta          = '0;
        i_meta_vld      = '0;
        i_emac_tx_ready = 1'b1;
        i_pmac_tx_ready = 1'b1;
        for (int ch = 0; ch < 2; ch++) begin
            rx_cnt[ch]     = 0;
            rx_first[ch]   = -1;
            vld_cycles[ch] = 0;
            rx_hold[ch]    = 1'b0;
        end
        test_reset();
        test_single(2, 1'b0);   // pmac
        test_single(5, 1'b1);   // emac
        test_strict_priority();
        test_backpressure();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: cross_data_cache.sv
module cross_data_cache #(
    parameter int DATA_W     = egress_pkg::DEF_DATA_W,
    parameter int PRI_NUM    = egress_pkg::DEF_PRI_NUM,
    parameter int DATA_DEPTH = egress_pkg::DEF_DATA_DEPTH,
    parameter int META_DEPTH = egress_pkg::DEF_META_DEPTH,
    parameter int MAX_FRAME  = egress_pkg::DEF_MAX_FRAME
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    input  logic [PRI_NUM-1:0][DATA_W-1:0]            i_data,
    input  logic [PRI_NUM-1:0]                        i_data_vld,
    input  logic [PRI_NUM-1:0][egress_pkg::META_W-1:0] i_meta,
    input  logic [PRI_NUM-1:0]                        i_meta_vld,
    output logic [PRI_NUM-1:0]                        o_pri_ready,
    output logic [PRI_NUM-1:0]                        o_fifoc_empty,
    output logic [DATA_W-1:0]                         o_emac_tx_data,
    output logic                                      o_emac_tx_valid,
    output logic                                      o_emac_tx_last,
    input  logic                                      i_emac_tx_ready,
    output logic [DATA_W-1:0]                         o_pmac_tx_data,
    output logic                                      o_pmac_tx_valid,
    output logic                                      o_pmac_tx_last,
    input  logic                                      i_pmac_tx_ready
);

    import egress_pkg::*;

    logic [PRI_NUM-1:0][DATA_W-1:0] w_head_data;
    logic [PRI_NUM-1:0][META_W-1:0] w_head_meta;
    logic [PRI_NUM-1:0]             w_frame_avail;
    logic [PRI_NUM-1:0]             w_data_pop;
    logic [PRI_NUM-1:0]             w_meta_pop;
    logic [PRI_NUM-1:0]             w_grant;
    logic                           w_start;
    logic                           w_done;

    for (genvar p = 0; p < PRI_NUM; p++) begin : g_queue
        pri_queue #(
            .DATA_W     (DATA_W),
            .DATA_DEPTH (DATA_DEPTH),
            .META_DEPTH (META_DEPTH),
            .MAX_FRAME  (MAX_FRAME)
        ) u_pri_queue (
            .i_clk         (i_clk),
            .i_rst         (i_rst),
            .i_data        (i_data[p]),
            .i_data_vld    (i_data_vld[p]),
            .i_meta        (i_meta[p]),
            .i_meta_vld    (i_meta_vld[p]),
            .i_data_pop    (w_data_pop[p]),
            .i_meta_pop    (w_meta_pop[p]),
            .o_head_data   (w_head_data[p]),
            .o_head_meta   (w_head_meta[p]),
            .o_frame_avail (w_frame_avail[p]),
            .o_ready       (o_pri_ready[p])
        );
    end

    // Empty flag seen by the scheduling pipeline
    assign o_fifoc_empty = ~w_frame_avail;

    frame_sched #(
        .PRI_NUM (PRI_NUM)
    ) u_frame_sched (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_frame_avail (w_frame_avail),
        .i_tx_done     (w_done),
        .o_grant       (w_grant),
        .o_start       (w_start)
    );

    frame_tx #(
        .DATA_W  (DATA_W),
        .PRI_NUM (PRI_NUM)
    ) u_frame_tx (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_start         (w_start),
        .i_grant         (w_grant),
        .i_head_meta     (w_head_meta),
        .i_head_data     (w_head_data),
        .o_meta_pop      (w_meta_pop),
        .o_data_pop      (w_data_pop),
        .o_done          (w_done),
        .o_emac_tx_data  (o_emac_tx_data),
        .o_emac_tx_valid (o_emac_tx_valid),
        .o_emac_tx_last  (o_emac_tx_last),
        .i_emac_tx_ready (i_emac_tx_ready),
        .o_pmac_tx_data  (o_pmac_tx_data),
        .o_pmac_tx_valid (o_pmac_tx_valid),
        .o_pmac_tx_last  (o_pmac_tx_last),
        .i_pmac_tx_ready (i_pmac_tx_ready)
    );

endmodule

// File: frame_tx.sv
module frame_tx #(
    parameter int DATA_W  = egress_pkg::DEF_DATA_W,
    parameter int PRI_NUM = egress_pkg::DEF_PRI_NUM
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    input  logic                                      i_start,
    input  logic [PRI_NUM-1:0]                        i_grant,
    input  logic [PRI_NUM-1:0][egress_pkg::META_W-1:0] i_head_meta,
    input  logic [PRI_NUM-1:0][DATA_W-1:0]            i_head_data,
    output logic [PRI_NUM-1:0]                        o_meta_pop,
    output logic [PRI_NUM-1:0]                        o_data_pop,
    output logic                                      o_done,
    output logic [DATA_W-1:0]                         o_emac_tx_data,
    output logic                                      o_emac_tx_valid,
    output logic                                      o_emac_tx_last,
    input  logic                                      i_emac_tx_ready,
    output logic [DATA_W-1:0]                         o_pmac_tx_data,
    output logic                                      o_pmac_tx_valid,
    output logic                                      o_pmac_tx_last,
    input  logic                                      i_pmac_tx_ready
);

    import egress_pkg::*;

    logic [META_W-1:0] w_sel_meta;
    logic [DATA_W-1:0] w_sel_data;
    logic [LEN_W-1:0]  w_len;
    logic              w_ready;
    logic              w_fire;
    logic              w_next;

    logic [DATA_W-1:0] r_data;
    logic              r_valid;
    logic              r_last;
    logic              r_express;
    logic [LEN_W-1:0]  r_remain;   // Bytes still in the data FIFO

    always_comb begin
        w_sel_meta = '0;
        w_sel_data = '0;
        for (int p = 0; p < PRI_NUM; p++) begin
            if (i_grant[p]) begin
                w_sel_meta = i_head_meta[p];
                w_sel_data = i_head_data[p];
            end
        end
    end

    assign w_len   = w_sel_meta[LEN_W-1:0];
    assign w_ready = r_express ? i_emac_tx_ready : i_pmac_tx_ready;
    assign w_fire  = r_valid & w_ready;
    // Load first byte on start, then one per accepted byte
    assign w_next  = i_start | (w_fire & (r_remain != '0));

    assign o_meta_pop = {PRI_NUM{i_start}} & i_grant;
    assign o_data_pop = {PRI_NUM{w_next}} & i_grant;
    assign o_done     = w_fire & r_last;

    always_ff @(posedge i_clk) begin
        if (w_next) begin
            r_data <= w_sel_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_valid   <= 1'b0;
            r_last    <= 1'b0;
            r_express <= 1'b0;
            r_remain  <= '0;
        end else if (i_start) begin
            r_valid   <= 1'b1;
            r_last    <= (w_len == LEN_W'(1));
            r_express <= w_sel_meta[EXPRESS_BIT];
            r_remain  <= w_len - 1'b1;
        end else if (w_next) begin
            r_last   <= (r_remain == LEN_W'(1));
            r_remain <= r_remain - 1'b1;
        end else if (w_fire) begin
            r_valid <= 1'b0;   // Final byte gone
            r_last  <= 1'b0;
        end
    end

    // Channel steered by the express flag
    assign o_emac_tx_data  = r_data;
    assign o_emac_tx_valid = r_valid & r_express;
    assign o_emac_tx_last  = r_last & r_express;
    assign o_pmac_tx_data  = r_data;
    assign o_pmac_tx_valid = r_valid & ~r_express;
    assign o_pmac_tx_last  = r_last & ~r_express;

endmodule

// File: frame_sched.sv
module frame_sched #(
    parameter int PRI_NUM = egress_pkg::DEF_PRI_NUM
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic [PRI_NUM-1:0] i_frame_avail,
    input  logic               i_tx_done,
    output logic [PRI_NUM-1:0] o_grant,
    output logic               o_start
);

    logic [PRI_NUM-1:0] w_pick;
    logic [PRI_NUM-1:0] r_grant;
    logic               r_start;
    logic               r_busy;

    // Highest set bit wins
    always_comb begin
        w_pick = '0;
        for (int i = 0; i < PRI_NUM; i++) begin
            if (i_frame_avail[i]) begin
                w_pick    = '0;
                w_pick[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_grant <= '0;
            r_start <= 1'b0;
            r_busy  <= 1'b0;
        end else begin
            r_start <= 1'b0;
            if (r_busy) begin
                if (i_tx_done) begin   // Frame finished, release lock
                    r_busy  <= 1'b0;
                    r_grant <= '0;
                end
            end else if (|i_frame_avail) begin
                r_grant <= w_pick;
                r_start <= 1'b1;
                r_busy  <= 1'b1;
            end
        end
    end

    assign o_grant = r_grant;
    assign o_start = r_start;

endmodule

// File: pri_queue.sv
module pri_queue #(
    parameter int DATA_W     = egress_pkg::DEF_DATA_W,
    parameter int DATA_DEPTH = egress_pkg::DEF_DATA_DEPTH,
    parameter int META_DEPTH = egress_pkg::DEF_META_DEPTH,
    parameter int MAX_FRAME  = egress_pkg::DEF_MAX_FRAME
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [DATA_W-1:0]         i_data,
    input  logic                      i_data_vld,
    input  logic [egress_pkg::META_W-1:0] i_meta,
    input  logic                      i_meta_vld,
    input  logic                      i_data_pop,
    input  logic                      i_meta_pop,
    output logic [DATA_W-1:0]         o_head_data,
    output logic [egress_pkg::META_W-1:0] o_head_meta,
    output logic                      o_frame_avail,
    output logic                      o_ready
);

    import egress_pkg::*;

    localparam int CNT_W = $clog2(DATA_DEPTH + 1);
    // Highest fill that still leaves room for a full frame plus slack
    localparam logic [CNT_W-1:0] READY_LEVEL = CNT_W'(DATA_DEPTH - MAX_FRAME - 2);

    logic [CNT_W-1:0] w_data_count;
    logic             w_meta_full;
    logic             w_meta_empty;
    logic             r_ready;

    sync_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (DATA_DEPTH)
    ) u_data_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wr_en (i_data_vld),
        .i_din   (i_data),
        .i_rd_en (i_data_pop),
        .o_dout  (o_head_data),
        .o_full  (),
        .o_empty (),
        .o_count (w_data_count)
    );

    sync_fifo #(
        .WIDTH (META_W),
        .DEPTH (META_DEPTH)
    ) u_meta_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wr_en (i_meta_vld),
        .i_din   (i_meta),
        .i_rd_en (i_meta_pop),
        .o_dout  (o_head_meta),
        .o_full  (w_meta_full),
        .o_empty (w_meta_empty),
        .o_count ()
    );

    // Need room in both FIFOs before a new frame may start
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_ready <= 1'b0;
        end else begin
            r_ready <= (w_data_count <= READY_LEVEL) & ~w_meta_full;
        end
    end

    assign o_ready       = r_ready;
    assign o_frame_avail = ~w_meta_empty;   // Metadata present means whole frame stored

endmodule

// File: sync_fifo.sv
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_wr_en,
    input  logic [WIDTH-1:0]           i_din,
    input  logic                       i_rd_en,
    output logic [WIDTH-1:0]           o_dout,
    output logic                       o_full,
    output logic                       o_empty,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    r_wr_ptr;
    logic [AW-1:0]    r_rd_ptr;
    logic [CW-1:0]    r_count;
    logic             w_wr;
    logic             w_rd;

    assign o_full  = (r_count == CW'(DEPTH));
    assign o_empty = (r_count == '0);
    assign o_count = r_count;

    assign w_wr = i_wr_en & ~o_full;   // Drop writes when full
    assign w_rd = i_rd_en & ~o_empty;

    // Head word always on the output
    assign o_dout = mem[r_rd_ptr];

    always_ff @(posedge i_clk) begin
        if (w_wr) begin
            mem[r_wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (w_wr) begin
                r_wr_ptr <= (r_wr_ptr == AW'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_rd) begin
                r_rd_ptr <= (r_rd_ptr == AW'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_count <= '0;
        end else begin
            case ({w_wr, w_rd})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;   // Both or neither
            endcase
        end
    end

endmodule

// File: egress_pkg.sv
package egress_pkg;

    // Metadata word layout: [11] express, [10:0] frame length
    localparam int LEN_W       = 11;
    localparam int META_W      = 12;
    localparam int EXPRESS_BIT = 11;

    // Defaults for the egress cache
    localparam int DEF_DATA_W     = 8;
    localparam int DEF_PRI_NUM    = 8;
    localparam int DEF_DATA_DEPTH = 256;   // Bytes per priority
    localparam int DEF_META_DEPTH = 32;    // Frames per priority
    localparam int DEF_MAX_FRAME  = 64;    // Longest frame in words

endpackage
